//--- include/binner_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tile binner widths and tile size
// edge width must hold a*x + b*y + c without overflow
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef BINNER_SETTINGS_SVH
`define BINNER_SETTINGS_SVH
`default_nettype none

// tile edge length in pixels
`define BINNER_TILE_SIZE 8

`define BINNER_COEF_W 16
`define BINNER_COORD_W 12
// two 29-bit products plus c
`define BINNER_EDGE_W 32
`define BINNER_TILE_CNT_W 8

`default_nettype wire
`endif

//--- logic/binner_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared scalar types of the tile binner
// all widths come from binner_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "binner_settings.svh"
`default_nettype none

package binner_pkg;

    // one signed edge coefficient
    typedef logic signed [`BINNER_COEF_W-1:0] coef_t;

    // unsigned pixel coordinate
    typedef logic [`BINNER_COORD_W-1:0] coord_t;

    // tiles along one axis
    typedef logic [`BINNER_TILE_CNT_W-1:0] tile_cnt_t;

    // edge function value at a corner
    typedef logic signed [`BINNER_EDGE_W-1:0] edge_val_t;

    // corner index
    // bit 0 adds the tile size in x and bit 1 adds it in y
    // 0 is lower left and 3 is upper right
    typedef logic [1:0] corner_t;

endpackage

`default_nettype wire

//--- logic/binner_setup.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// holds one triangle's coefficients and corners
// values are stable until the next i_load
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module binner_setup (
    input  logic                clk,
    input  logic                i_reset,
    input  logic                i_load,
    input  binner_pkg::coef_t   i_e0_a,
    input  binner_pkg::coef_t   i_e0_b,
    input  binner_pkg::coef_t   i_e0_c,
    input  binner_pkg::coef_t   i_e1_a,
    input  binner_pkg::coef_t   i_e1_b,
    input  binner_pkg::coef_t   i_e1_c,
    input  binner_pkg::coef_t   i_e2_a,
    input  binner_pkg::coef_t   i_e2_b,
    input  binner_pkg::coef_t   i_e2_c,
    output binner_pkg::coef_t   o_a [3],
    output binner_pkg::coef_t   o_b [3],
    output binner_pkg::coef_t   o_c [3],
    output binner_pkg::corner_t o_tr_corner [3],
    output binner_pkg::corner_t o_ta_corner [3]
);
    import binner_pkg::*;

    // largest value of a*x + b*y sits at +x when a >= 0 and at +y when b >= 0
    function automatic corner_t tr_corner(input coef_t a, input coef_t b);
        return corner_t'({b >= 0, a >= 0});
    endfunction

    always_ff @(posedge clk) begin
        if (i_load) begin
            o_a[0] <= i_e0_a;
            o_b[0] <= i_e0_b;
            o_c[0] <= i_e0_c;
            o_a[1] <= i_e1_a;
            o_b[1] <= i_e1_b;
            o_c[1] <= i_e1_c;
            o_a[2] <= i_e2_a;
            o_b[2] <= i_e2_b;
            o_c[2] <= i_e2_c;
        end
    end

    // TA corner is the diagonal opposite, so every bit flips
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_tr_corner <= '{default: '0};
            o_ta_corner <= '{default: '0};
        end else if (i_load) begin
            o_tr_corner[0] <= tr_corner(i_e0_a, i_e0_b);
            o_tr_corner[1] <= tr_corner(i_e1_a, i_e1_b);
            o_tr_corner[2] <= tr_corner(i_e2_a, i_e2_b);
            o_ta_corner[0] <= ~tr_corner(i_e0_a, i_e0_b);
            o_ta_corner[1] <= ~tr_corner(i_e1_a, i_e1_b);
            o_ta_corner[2] <= ~tr_corner(i_e2_a, i_e2_b);
        end
    end

endmodule

`default_nettype wire

//--- logic/binner_tile_walker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// row-major walk over the tile rectangle
// tile counts must be at least 1
// a new triangle is taken only when o_busy is low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "binner_settings.svh"
`default_nettype none

module binner_tile_walker (
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic                  i_valid,
    input  logic                  i_full,
    input  binner_pkg::coord_t    i_min_x,
    input  binner_pkg::coord_t    i_min_y,
    input  binner_pkg::tile_cnt_t i_tiles_x,
    input  binner_pkg::tile_cnt_t i_tiles_y,
    output logic                  o_load,
    output binner_pkg::coord_t    o_tile_x,
    output binner_pkg::coord_t    o_tile_y,
    output logic                  o_issue,
    output logic                  o_busy
);
    import binner_pkg::*;

    localparam coord_t TILE_STEP = coord_t'(`BINNER_TILE_SIZE);

    // triangle rectangle, held for the whole walk
    coord_t    r_min_x;
    tile_cnt_t r_tiles_x;
    tile_cnt_t r_tiles_y;

    coord_t    r_tile_x;
    coord_t    r_tile_y;
    tile_cnt_t r_col;
    tile_cnt_t r_row;
    logic      r_issue;

    // issued tiles in eval stage 1, eval stage 2 and classify
    logic [2:0] r_in_flight;

    logic w_accept;
    logic w_row_end;
    logic w_last;

    assign o_busy   = r_issue | (|r_in_flight);
    assign w_accept = i_valid & ~o_busy;
    assign o_load   = w_accept;

    assign w_row_end = (r_col == tile_cnt_t'(r_tiles_x - 1'b1));
    assign w_last    = w_row_end && (r_row == tile_cnt_t'(r_tiles_y - 1'b1));

    always_ff @(posedge clk) begin
        if (i_reset) begin
            r_issue     <= 1'b0;
            r_in_flight <= '0;
            r_col       <= '0;
            r_row       <= '0;
        end else if (w_accept) begin
            // pipeline is empty here, first tile goes out next cycle
            r_issue <= 1'b1;
            r_col   <= '0;
            r_row   <= '0;
        end else if (!i_full) begin
            r_in_flight <= {r_in_flight[1:0], r_issue};
            if (r_issue) begin
                if (w_last) begin
                    r_issue <= 1'b0;
                end
                if (w_row_end) begin
                    r_col <= '0;
                    r_row <= r_row + 1'b1;
                end else begin
                    r_col <= r_col + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (w_accept) begin
            r_min_x   <= i_min_x;
            r_tiles_x <= i_tiles_x;
            r_tiles_y <= i_tiles_y;
            r_tile_x  <= i_min_x;
            r_tile_y  <= i_min_y;
        end else if (!i_full && r_issue) begin
            // wrap to the start of the next row
            if (w_row_end) begin
                r_tile_x <= r_min_x;
                r_tile_y <= r_tile_y + TILE_STEP;
            end else begin
                r_tile_x <= r_tile_x + TILE_STEP;
            end
        end
    end

    assign o_tile_x = r_tile_x;
    assign o_tile_y = r_tile_y;
    assign o_issue  = r_issue;

endmodule

`default_nettype wire

//--- logic/binner_edge_eval.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-stage edge evaluation at TR and TA corners
// coefficients must stay constant while tiles are in flight
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "binner_settings.svh"
`default_nettype none

module binner_edge_eval (
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic                  i_full,
    input  logic                  i_issue,
    input  binner_pkg::coord_t    i_tile_x,
    input  binner_pkg::coord_t    i_tile_y,
    input  binner_pkg::coef_t     i_a [3],
    input  binner_pkg::coef_t     i_b [3],
    input  binner_pkg::coef_t     i_c [3],
    input  binner_pkg::corner_t   i_tr_corner [3],
    input  binner_pkg::corner_t   i_ta_corner [3],
    output logic                  o_valid,
    output binner_pkg::coord_t    o_tile_x,
    output binner_pkg::coord_t    o_tile_y,
    output binner_pkg::edge_val_t o_e_tr [3],
    output binner_pkg::edge_val_t o_e_ta [3]
);
    import binner_pkg::*;

    // stage 1 products
    edge_val_t r_ax_tr [3];
    edge_val_t r_by_tr [3];
    edge_val_t r_ax_ta [3];
    edge_val_t r_by_ta [3];
    coord_t    r_x1;
    coord_t    r_y1;
    logic      r_v1;

    // pixel position of a corner along one axis
    function automatic edge_val_t corner_pos(input coord_t base, input logic sel);
        edge_val_t pos;
        pos = edge_val_t'(base);
        if (sel) begin
            pos = pos + `BINNER_TILE_SIZE;
        end
        return pos;
    endfunction

    always_ff @(posedge clk) begin
        if (!i_full) begin
            for (int e = 0; e < 3; e++) begin
                r_ax_tr[e] <= edge_val_t'(i_a[e]) * corner_pos(i_tile_x, i_tr_corner[e][0]);
                r_by_tr[e] <= edge_val_t'(i_b[e]) * corner_pos(i_tile_y, i_tr_corner[e][1]);
                r_ax_ta[e] <= edge_val_t'(i_a[e]) * corner_pos(i_tile_x, i_ta_corner[e][0]);
                r_by_ta[e] <= edge_val_t'(i_b[e]) * corner_pos(i_tile_y, i_ta_corner[e][1]);
                // stage 2
                o_e_tr[e] <= r_ax_tr[e] + r_by_tr[e] + edge_val_t'(i_c[e]);
                o_e_ta[e] <= r_ax_ta[e] + r_by_ta[e] + edge_val_t'(i_c[e]);
            end
            r_x1     <= i_tile_x;
            r_y1     <= i_tile_y;
            o_tile_x <= r_x1;
            o_tile_y <= r_y1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            r_v1    <= 1'b0;
            o_valid <= 1'b0;
        end else if (!i_full) begin
            r_v1    <= i_issue;
            o_valid <= r_v1;
        end
    end

endmodule

`default_nettype wire

//--- logic/binner_tile_classify.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trivial reject and accept of one tile per cycle
// output is held while i_full is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module binner_tile_classify (
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic                  i_full,
    input  logic                  i_valid,
    input  binner_pkg::coord_t    i_tile_x,
    input  binner_pkg::coord_t    i_tile_y,
    input  binner_pkg::edge_val_t i_e_tr [3],
    input  binner_pkg::edge_val_t i_e_ta [3],
    output logic                  o_tile_valid,
    output binner_pkg::coord_t    o_tile_x,
    output binner_pkg::coord_t    o_tile_y,
    output logic                  o_tile_full
);
    import binner_pkg::*;

    logic w_reject;
    logic w_covered;

    // any TR value below zero puts the tile outside that edge
    always_comb begin
        w_reject  = 1'b0;
        w_covered = 1'b1;
        for (int e = 0; e < 3; e++) begin
            if (i_e_tr[e] < 0) begin
                w_reject = 1'b1;
            end
            if (i_e_ta[e] < 0) begin
                w_covered = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_tile_valid <= 1'b0;
        end else if (!i_full) begin
            o_tile_valid <= i_valid & ~w_reject;
        end
    end

    // full tiles go to the shader, the rest to the rasterizer
    always_ff @(posedge clk) begin
        if (!i_full) begin
            o_tile_x    <= i_tile_x;
            o_tile_y    <= i_tile_y;
            o_tile_full <= w_covered;
        end
    end

endmodule

`default_nettype wire

//--- logic/tile_binner.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tile binner top, one tile per unstalled cycle
// tile reaches the outputs three cycles after issue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tile_binner (
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic                  i_valid,
    input  binner_pkg::coef_t     i_e0_a,
    input  binner_pkg::coef_t     i_e0_b,
    input  binner_pkg::coef_t     i_e0_c,
    input  binner_pkg::coef_t     i_e1_a,
    input  binner_pkg::coef_t     i_e1_b,
    input  binner_pkg::coef_t     i_e1_c,
    input  binner_pkg::coef_t     i_e2_a,
    input  binner_pkg::coef_t     i_e2_b,
    input  binner_pkg::coef_t     i_e2_c,
    input  binner_pkg::coord_t    i_min_x,
    input  binner_pkg::coord_t    i_min_y,
    input  binner_pkg::tile_cnt_t i_tiles_x,
    input  binner_pkg::tile_cnt_t i_tiles_y,
    input  logic                  i_full,
    output binner_pkg::coord_t    o_tile_x,
    output binner_pkg::coord_t    o_tile_y,
    output logic                  o_tile_valid,
    output logic                  o_tile_full,
    output logic                  o_busy
);
    import binner_pkg::*;

    // walker to setup and eval
    logic      w_load;
    logic      w_issue;
    coord_t    w_walk_x;
    coord_t    w_walk_y;

    // setup to eval
    coef_t     w_a [3];
    coef_t     w_b [3];
    coef_t     w_c [3];
    corner_t   w_tr_corner [3];
    corner_t   w_ta_corner [3];

    // eval to classify
    logic      w_eval_valid;
    coord_t    w_eval_x;
    coord_t    w_eval_y;
    edge_val_t w_e_tr [3];
    edge_val_t w_e_ta [3];

    binner_tile_walker u_walker (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_valid   (i_valid),
        .i_full    (i_full),
        .i_min_x   (i_min_x),
        .i_min_y   (i_min_y),
        .i_tiles_x (i_tiles_x),
        .i_tiles_y (i_tiles_y),
        .o_load    (w_load),
        .o_tile_x  (w_walk_x),
        .o_tile_y  (w_walk_y),
        .o_issue   (w_issue),
        .o_busy    (o_busy)
    );

    binner_setup u_setup (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_load      (w_load),
        .i_e0_a      (i_e0_a),
        .i_e0_b      (i_e0_b),
        .i_e0_c      (i_e0_c),
        .i_e1_a      (i_e1_a),
        .i_e1_b      (i_e1_b),
        .i_e1_c      (i_e1_c),
        .i_e2_a      (i_e2_a),
        .i_e2_b      (i_e2_b),
        .i_e2_c      (i_e2_c),
        .o_a         (w_a),
        .o_b         (w_b),
        .o_c         (w_c),
        .o_tr_corner (w_tr_corner),
        .o_ta_corner (w_ta_corner)
    );

    binner_edge_eval u_edge_eval (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_full      (i_full),
        .i_issue     (w_issue),
        .i_tile_x    (w_walk_x),
        .i_tile_y    (w_walk_y),
        .i_a         (w_a),
        .i_b         (w_b),
        .i_c         (w_c),
        .i_tr_corner (w_tr_corner),
        .i_ta_corner (w_ta_corner),
        .o_valid     (w_eval_valid),
        .o_tile_x    (w_eval_x),
        .o_tile_y    (w_eval_y),
        .o_e_tr      (w_e_tr),
        .o_e_ta      (w_e_ta)
    );

    binner_tile_classify u_classify (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_full       (i_full),
        .i_valid      (w_eval_valid),
        .i_tile_x     (w_eval_x),
        .i_tile_y     (w_eval_y),
        .i_e_tr       (w_e_tr),
        .i_e_ta       (w_e_ta),
        .o_tile_valid (o_tile_valid),
        .o_tile_x     (o_tile_x),
        .o_tile_y     (o_tile_y),
        .o_tile_full  (o_tile_full)
    );

endmodule

`default_nettype wire

//--- sim/binner_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reset, stall and busy rules of tile_binner
// bound to every tile_binner instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module binner_assertions (
    input logic               clk,
    input logic               i_reset,
    input logic               i_full,
    input logic               i_tile_valid,
    input binner_pkg::coord_t i_tile_x,
    input binner_pkg::coord_t i_tile_y,
    input logic               i_tile_full,
    input logic               i_busy
);
    timeunit 1ns;
    timeprecision 100ps;

    reset_clears_outputs: assert property (
        @(posedge clk) i_reset |=> (!i_tile_valid && !i_busy)
    ) else $error("o_tile_valid or o_busy high after reset");

    // a held tile keeps its position and class until delivered
    stall_holds_tile: assert property (
        @(posedge clk) disable iff (i_reset)
        (i_tile_valid && i_full) |=> (i_tile_valid && $stable(i_tile_x)
                                      && $stable(i_tile_y) && $stable(i_tile_full))
    ) else $error("tile output changed while stalled");

    busy_covers_tile: assert property (
        @(posedge clk) disable iff (i_reset) i_tile_valid |-> i_busy
    ) else $error("o_tile_valid high while o_busy low");

endmodule

bind tile_binner binner_assertions u_assertions (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_full       (i_full),
    .i_tile_valid (o_tile_valid),
    .i_tile_x     (o_tile_x),
    .i_tile_y     (o_tile_y),
    .i_tile_full  (o_tile_full),
    .i_busy       (o_busy)
);

`default_nettype wire

//--- sim/binner_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model and scoreboard for tile_binner
// samples on the falling edge, expects row-major order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "binner_settings.svh"
`default_nettype none

module binner_checker (
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic                  i_valid,
    input  binner_pkg::coef_t     i_e0_a,
    input  binner_pkg::coef_t     i_e0_b,
    input  binner_pkg::coef_t     i_e0_c,
    input  binner_pkg::coef_t     i_e1_a,
    input  binner_pkg::coef_t     i_e1_b,
    input  binner_pkg::coef_t     i_e1_c,
    input  binner_pkg::coef_t     i_e2_a,
    input  binner_pkg::coef_t     i_e2_b,
    input  binner_pkg::coef_t     i_e2_c,
    input  binner_pkg::coord_t    i_min_x,
    input  binner_pkg::coord_t    i_min_y,
    input  binner_pkg::tile_cnt_t i_tiles_x,
    input  binner_pkg::tile_cnt_t i_tiles_y,
    input  logic                  i_full,
    input  logic                  i_busy,
    input  logic                  i_tile_valid,
    input  binner_pkg::coord_t    i_tile_x,
    input  binner_pkg::coord_t    i_tile_y,
    input  logic                  i_tile_full,
    input  logic                  i_count_check,
    input  int                    i_exp_full,
    input  int                    i_exp_part,
    output int                    o_errors
);
    timeunit 1ns;
    timeprecision 100ps;
    import binner_pkg::*;

    localparam int TS = `BINNER_TILE_SIZE;

    // expected tiles of the current triangle, oldest first
    int exp_x [$];
    int exp_y [$];
    bit exp_full [$];

    int errors   = 0;
    int got_full = 0;
    int got_part = 0;

    assign o_errors = errors;

    function automatic longint edge_value(input int a, input int b, input int c,
                                          input int x, input int y);
        return longint'(a) * longint'(x) + longint'(b) * longint'(y) + longint'(c);
    endfunction

    task automatic queue_triangle();
        int     a [3];
        int     b [3];
        int     c [3];
        int     x;
        int     y;
        longint tr;
        longint ta;
        bit     reject;
        bit     covered;
        a = '{int'(i_e0_a), int'(i_e1_a), int'(i_e2_a)};
        b = '{int'(i_e0_b), int'(i_e1_b), int'(i_e2_b)};
        c = '{int'(i_e0_c), int'(i_e1_c), int'(i_e2_c)};
        for (int row = 0; row < int'(i_tiles_y); row++) begin
            for (int col = 0; col < int'(i_tiles_x); col++) begin
                x       = int'(i_min_x) + col * TS;
                y       = int'(i_min_y) + row * TS;
                reject  = 1'b0;
                covered = 1'b1;
                for (int e = 0; e < 3; e++) begin
                    // largest value sits one tile along each axis with a coefficient >= 0
                    tr = edge_value(a[e], b[e], c[e],
                                    x + ((a[e] >= 0) ? TS : 0), y + ((b[e] >= 0) ? TS : 0));
                    ta = edge_value(a[e], b[e], c[e],
                                    x + ((a[e] >= 0) ? 0 : TS), y + ((b[e] >= 0) ? 0 : TS));
                    if (tr < 0) begin
                        reject = 1'b1;
                    end
                    if (ta < 0) begin
                        covered = 1'b0;
                    end
                end
                if (!reject) begin
                    exp_x.push_back(x);
                    exp_y.push_back(y);
                    exp_full.push_back(covered);
                end
            end
        end
    endtask

    task automatic compare_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("MISMATCH time=%0t signal=%s expected=%0d actual=%0d",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_tile();
        if (exp_x.size() == 0) begin
            $display("error at %0t: tile (%0d,%0d) delivered when no tile was expected",
                     $time, i_tile_x, i_tile_y);
            errors++;
        end else begin
            compare_value("o_tile_x", exp_x.pop_front(), int'(i_tile_x));
            compare_value("o_tile_y", exp_y.pop_front(), int'(i_tile_y));
            compare_value("o_tile_full", int'(exp_full.pop_front()), int'(i_tile_full));
        end
        if (i_tile_full) begin
            got_full++;
        end else begin
            got_part++;
        end
    endtask

    task automatic check_counts();
        compare_value("full_tile_count", i_exp_full, got_full);
        compare_value("partial_tile_count", i_exp_part, got_part);
        if (exp_x.size() != 0) begin
            $display("error at %0t: %0d expected tiles were never delivered",
                     $time, exp_x.size());
            errors++;
            exp_x.delete();
            exp_y.delete();
            exp_full.delete();
        end
    endtask

    always @(negedge clk) begin
        if (!i_reset) begin
            // a triangle is taken only while idle
            if (i_valid && !i_busy) begin
                got_full = 0;
                got_part = 0;
                queue_triangle();
            end
            if (i_tile_valid && !i_full) begin
                check_tile();
            end
            if (i_count_check) begin
                check_counts();
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_tile_binner.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for tile_binner, the triangle table runs twice
// second pass stalls the output with random i_full
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_tile_binner;
    timeunit 1ns;
    timeprecision 100ps;
    import binner_pkg::*;

    localparam int NUM_TRI  = 6;
    localparam int MAX_WAIT = 1000;

    // columns: e0 a b c, e1 a b c, e2 a b c, min x, min y, tiles x, tiles y,
    // expected full tiles, expected partial tiles
    int tri_table [NUM_TRI][15] = '{
        '{ 1,  0,    0,  0,  1,   0, -1, -1, 100,  16,   8, 3, 2, 6,  0},
        '{-1,  0,   20,  0,  1,   0,  1,  0,   0,   0,   0, 4, 2, 4,  2},
        '{ 1,  1, -100,  0,  0,   1,  0,  0,   1,   0,   0, 2, 2, 0,  0},
        '{ 1,  1,  -12, -1,  1,   8,  1, -1,   8,   0,   0, 4, 4, 3, 11},
        '{-1, -1,   60,  2,  0, -20,  0, -3, 120,   8,  16, 3, 3, 3,  6},
        '{ 0,  0,    0,  0,  0,   0,  0,  0,   0, 100, 200, 1, 1, 1,  0}
    };

    logic        clk;
    logic        i_reset;
    logic        i_valid;
    coef_t       i_e0_a;
    coef_t       i_e0_b;
    coef_t       i_e0_c;
    coef_t       i_e1_a;
    coef_t       i_e1_b;
    coef_t       i_e1_c;
    coef_t       i_e2_a;
    coef_t       i_e2_b;
    coef_t       i_e2_c;
    coord_t      i_min_x;
    coord_t      i_min_y;
    tile_cnt_t   i_tiles_x;
    tile_cnt_t   i_tiles_y;
    logic        i_full;
    coord_t      o_tile_x;
    coord_t      o_tile_y;
    logic        o_tile_valid;
    logic        o_tile_full;
    logic        o_busy;

    logic        stall_en;
    logic        count_check;
    int          exp_full;
    int          exp_part;
    int          check_errors;
    int          timeouts;
    integer      seed;
    logic [31:0] rnd;

    tile_binner UUT (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_valid      (i_valid),
        .i_e0_a       (i_e0_a),
        .i_e0_b       (i_e0_b),
        .i_e0_c       (i_e0_c),
        .i_e1_a       (i_e1_a),
        .i_e1_b       (i_e1_b),
        .i_e1_c       (i_e1_c),
        .i_e2_a       (i_e2_a),
        .i_e2_b       (i_e2_b),
        .i_e2_c       (i_e2_c),
        .i_min_x      (i_min_x),
        .i_min_y      (i_min_y),
        .i_tiles_x    (i_tiles_x),
        .i_tiles_y    (i_tiles_y),
        .i_full       (i_full),
        .o_tile_x     (o_tile_x),
        .o_tile_y     (o_tile_y),
        .o_tile_valid (o_tile_valid),
        .o_tile_full  (o_tile_full),
        .o_busy       (o_busy)
    );

    binner_checker u_checker (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_valid       (i_valid),
        .i_e0_a        (i_e0_a),
        .i_e0_b        (i_e0_b),
        .i_e0_c        (i_e0_c),
        .i_e1_a        (i_e1_a),
        .i_e1_b        (i_e1_b),
        .i_e1_c        (i_e1_c),
        .i_e2_a        (i_e2_a),
        .i_e2_b        (i_e2_b),
        .i_e2_c        (i_e2_c),
        .i_min_x       (i_min_x),
        .i_min_y       (i_min_y),
        .i_tiles_x     (i_tiles_x),
        .i_tiles_y     (i_tiles_y),
        .i_full        (i_full),
        .i_busy        (o_busy),
        .i_tile_valid  (o_tile_valid),
        .i_tile_x      (o_tile_x),
        .i_tile_y      (o_tile_y),
        .i_tile_full   (o_tile_full),
        .i_count_check (count_check),
        .i_exp_full    (exp_full),
        .i_exp_part    (exp_part),
        .o_errors      (check_errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // random backpressure, about half the cycles
    always @(posedge clk) begin
        #1;
        rnd = $random(seed);
        i_full = stall_en & rnd[0];
    end

    task automatic wait_idle(input string what);
        int cycles;
        cycles = 0;
        while (o_busy && cycles < MAX_WAIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (o_busy) begin
            $display("timeout at %0t: DUT still busy %s", $time, what);
            timeouts++;
        end
    endtask

    task automatic load_triangle(input int r);
        i_e0_a    = coef_t'(tri_table[r][0]);
        i_e0_b    = coef_t'(tri_table[r][1]);
        i_e0_c    = coef_t'(tri_table[r][2]);
        i_e1_a    = coef_t'(tri_table[r][3]);
        i_e1_b    = coef_t'(tri_table[r][4]);
        i_e1_c    = coef_t'(tri_table[r][5]);
        i_e2_a    = coef_t'(tri_table[r][6]);
        i_e2_b    = coef_t'(tri_table[r][7]);
        i_e2_c    = coef_t'(tri_table[r][8]);
        i_min_x   = coord_t'(tri_table[r][9]);
        i_min_y   = coord_t'(tri_table[r][10]);
        i_tiles_x = tile_cnt_t'(tri_table[r][11]);
        i_tiles_y = tile_cnt_t'(tri_table[r][12]);
    endtask

    // covers every tile, so any tile from it would show up as unexpected
    task automatic load_ignored();
        i_e0_a    = '0;
        i_e0_b    = '0;
        i_e0_c    = coef_t'(1);
        i_e1_a    = '0;
        i_e1_b    = '0;
        i_e1_c    = coef_t'(1);
        i_e2_a    = '0;
        i_e2_b    = '0;
        i_e2_c    = coef_t'(1);
        i_min_x   = '0;
        i_min_y   = '0;
        i_tiles_x = tile_cnt_t'(2);
        i_tiles_y = tile_cnt_t'(2);
    endtask

    task automatic run_triangle(input int r);
        wait_idle("before a new triangle");
        load_triangle(r);
        i_valid = 1'b1;
        @(posedge clk);
        #1;
        // second offer lands while busy and must be dropped
        load_ignored();
        @(posedge clk);
        #1;
        i_valid = 1'b0;
        wait_idle("after the last tile");
        exp_full    = tri_table[r][13];
        exp_part    = tri_table[r][14];
        count_check = 1'b1;
        @(posedge clk);
        #1;
        count_check = 1'b0;
    endtask

    initial begin
        seed        = 32'hefa;
        timeouts    = 0;
        i_reset     = 1'b1;
        i_valid     = 1'b0;
        i_full      = 1'b0;
        stall_en    = 1'b0;
        count_check = 1'b0;
        exp_full    = 0;
        exp_part    = 0;
        load_ignored();
        repeat (3) @(posedge clk);
        #1;
        i_reset = 1'b0;
        for (int pass = 0; pass < 2; pass++) begin
            stall_en = (pass == 1);
            for (int r = 0; r < NUM_TRI; r++) begin
                run_triangle(r);
            end
        end
        stall_en = 1'b0;
        repeat (4) @(posedge clk);
        $display("errors: %0d from the checker, %0d timeouts", check_errors, timeouts);
        if (check_errors + timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
logic/binner_pkg.sv
logic/binner_setup.sv
logic/binner_tile_walker.sv
logic/binner_edge_eval.sv
logic/binner_tile_classify.sv
logic/tile_binner.sv
sim/binner_assertions.sv
sim/binner_checker.sv
sim/tb_tile_binner.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       = tb_tile_binner
FILELIST  = filelist.f
PASS_MSG  = Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
